/* include/hub_switch_consts.svh */
`ifndef HUB_SWITCH_CONSTS_SVH
`define HUB_SWITCH_CONSTS_SVH

// stream field widths
`define HUB_DATA_W 128
`define HUB_DEST_W 4
`define HUB_ID_W 2

// leaf i answers to tdest i+1, up to fifteen leaves with a 4-bit tdest
`define HUB_NUM_LEAF 4

// tdest that addresses the hub port
`define HUB_DEST_HUB 0

`endif

/* src/hub_switch_pkg.sv */
`include "hub_switch_consts.svh"

package hub_switch_pkg;

    typedef logic [`HUB_DATA_W-1:0] data_t;  // one beat payload
    typedef logic [`HUB_DEST_W-1:0] dest_t;
    typedef logic [`HUB_ID_W-1:0] id_t;

    // one bit per leaf port
    typedef logic [`HUB_NUM_LEAF-1:0] leaf_mask_t;

endpackage

/* src/axis_skid_slice.sv */
`timescale 1ns/1ps

module axis_skid_slice (
    input  logic                  clk,
    input  logic                  rst,
    input  hub_switch_pkg::data_t in_tdata,
    input  hub_switch_pkg::dest_t in_tdest,
    input  hub_switch_pkg::id_t   in_tid,
    input  logic                  in_tvalid,
    output logic                  in_tready,
    output hub_switch_pkg::data_t out_tdata,
    output hub_switch_pkg::dest_t out_tdest,
    output hub_switch_pkg::id_t   out_tid,
    output logic                  out_tvalid,
    input  logic                  out_tready
);

    hub_switch_pkg::data_t skid_tdata;
    hub_switch_pkg::dest_t skid_tdest;
    hub_switch_pkg::id_t   skid_tid;
    logic                  skid_valid;
    logic                  in_fire;
    logic                  main_free;

    // ready straight from the skid flop, never from out_tready
    assign in_tready = !skid_valid;
    assign in_fire   = in_tvalid && in_tready;
    assign main_free = !out_tvalid || out_tready;  // main empty or leaving

    always_ff @(posedge clk) begin
        if (rst) begin
            out_tvalid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            // skid beat is older, it goes first
            out_tvalid <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;  // main stalled, park the beat
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (main_free) begin
            if (skid_valid) begin
                out_tdata <= skid_tdata;
                out_tdest <= skid_tdest;
                out_tid   <= skid_tid;
            end else if (in_fire) begin
                out_tdata <= in_tdata;
                out_tdest <= in_tdest;
                out_tid   <= in_tid;
            end
        end else if (in_fire) begin
            skid_tdata <= in_tdata;
            skid_tdest <= in_tdest;
            skid_tid   <= in_tid;
        end
    end

endmodule

/* src/axis_hub_demux.sv */
`timescale 1ns/1ps
`include "hub_switch_consts.svh"

module axis_hub_demux (
    input  logic                  clk,
    input  logic                  rst,
    // beats from the hub
    input  hub_switch_pkg::data_t hub_tdata,
    input  hub_switch_pkg::dest_t hub_tdest,
    input  hub_switch_pkg::id_t   hub_tid,
    input  logic                  hub_tvalid,
    output logic                  hub_tready,
    // one stream per leaf slice
    output hub_switch_pkg::data_t leaf_tdata  [`HUB_NUM_LEAF],
    output hub_switch_pkg::dest_t leaf_tdest  [`HUB_NUM_LEAF],
    output hub_switch_pkg::id_t   leaf_tid    [`HUB_NUM_LEAF],
    output logic                  leaf_tvalid [`HUB_NUM_LEAF],
    input  logic                  leaf_tready [`HUB_NUM_LEAF]
);

    hub_switch_pkg::data_t      hold_tdata;
    hub_switch_pkg::dest_t      hold_tdest;
    hub_switch_pkg::id_t        hold_tid;
    logic                       hold_valid;
    hub_switch_pkg::leaf_mask_t dest_mask;
    hub_switch_pkg::leaf_mask_t sel_ready;
    logic                       hold_leave;

    // tdest i+1 selects leaf i, anything else gives an empty mask
    always_comb begin
        for (int i = 0; i < `HUB_NUM_LEAF; i++) begin
            dest_mask[i] = (hold_tdest == hub_switch_pkg::dest_t'(i + 1));
            sel_ready[i] = dest_mask[i] && leaf_tready[i];
        end
    end

    // only the selected leaf sees the beat
    always_comb begin
        for (int i = 0; i < `HUB_NUM_LEAF; i++) begin
            leaf_tvalid[i] = hold_valid && dest_mask[i];
            leaf_tdata[i]  = dest_mask[i] ? hold_tdata : '0;
            leaf_tdest[i]  = dest_mask[i] ? hold_tdest : '0;
            leaf_tid[i]    = dest_mask[i] ? hold_tid : '0;
        end
    end

    // discarded beats leave at once
    assign hold_leave = hold_valid && ((dest_mask == '0) || (sel_ready != '0));
    assign hub_tready = !hold_valid || hold_leave;

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (hub_tready) begin
            hold_valid <= hub_tvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (hub_tvalid && hub_tready) begin
            hold_tdata <= hub_tdata;
            hold_tdest <= hub_tdest;
            hold_tid   <= hub_tid;
        end
    end

endmodule

/* src/axis_leaf_arbiter.sv */
`timescale 1ns/1ps
`include "hub_switch_consts.svh"

module axis_leaf_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    // beats from the leaf inputs
    input  hub_switch_pkg::data_t leaf_tdata  [`HUB_NUM_LEAF],
    input  hub_switch_pkg::dest_t leaf_tdest  [`HUB_NUM_LEAF],
    input  hub_switch_pkg::id_t   leaf_tid    [`HUB_NUM_LEAF],
    input  logic                  leaf_tvalid [`HUB_NUM_LEAF],
    output logic                  leaf_tready [`HUB_NUM_LEAF],
    // to the hub output slice
    output hub_switch_pkg::data_t hub_tdata,
    output hub_switch_pkg::dest_t hub_tdest,
    output hub_switch_pkg::id_t   hub_tid,
    output logic                  hub_tvalid,
    input  logic                  hub_tready
);

    hub_switch_pkg::leaf_mask_t hub_req;
    hub_switch_pkg::leaf_mask_t disc_req;
    hub_switch_pkg::leaf_mask_t low_req;
    hub_switch_pkg::leaf_mask_t sel_mask;
    hub_switch_pkg::leaf_mask_t grant_mask;  // one-hot, nonzero while held

    // split valid leaves into hub-bound and discard
    always_comb begin
        for (int i = 0; i < `HUB_NUM_LEAF; i++) begin
            hub_req[i]  = leaf_tvalid[i] &&
                          (leaf_tdest[i] == hub_switch_pkg::dest_t'(`HUB_DEST_HUB));
            disc_req[i] = leaf_tvalid[i] && !hub_req[i];
        end
    end

    // isolate the lowest set bit, lowest index wins
    assign low_req  = hub_req & (~hub_req + 1'b1);
    assign sel_mask = (grant_mask != '0) ? grant_mask : low_req;

    // and-or mux over the selected leaf
    always_comb begin
        hub_tvalid = 1'b0;
        hub_tdata  = '0;
        hub_tdest  = '0;
        hub_tid    = '0;
        for (int i = 0; i < `HUB_NUM_LEAF; i++) begin
            if (sel_mask[i] && hub_req[i]) begin
                hub_tvalid = 1'b1;
                hub_tdata  = hub_tdata | leaf_tdata[i];
                hub_tdest  = hub_tdest | leaf_tdest[i];
                hub_tid    = hub_tid | leaf_tid[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `HUB_NUM_LEAF; i++) begin
            if (disc_req[i]) begin
                leaf_tready[i] = 1'b1;  // dropped here
            end else begin
                leaf_tready[i] = sel_mask[i] && hub_tready;
            end
        end
    end

    // hold the winner while its beat is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            grant_mask <= '0;
        end else if (hub_tvalid && !hub_tready) begin
            grant_mask <= sel_mask;
        end else begin
            grant_mask <= '0;
        end
    end

endmodule

/* src/axis_hub_switch.sv */
`timescale 1ns/1ps
`include "hub_switch_consts.svh"

module axis_hub_switch (
    input  logic                  clk,
    input  logic                  rst,

    // hub input, fans out to the leaves
    input  hub_switch_pkg::data_t hub_in_tdata,
    input  hub_switch_pkg::dest_t hub_in_tdest,
    input  hub_switch_pkg::id_t   hub_in_tid,
    input  logic                  hub_in_tvalid,
    output logic                  hub_in_tready,

    // hub output, fed by the leaf arbiter
    output hub_switch_pkg::data_t hub_out_tdata,
    output hub_switch_pkg::dest_t hub_out_tdest,
    output hub_switch_pkg::id_t   hub_out_tid,
    output logic                  hub_out_tvalid,
    input  logic                  hub_out_tready,

    // leaf inputs
    input  hub_switch_pkg::data_t leaf_in_tdata   [`HUB_NUM_LEAF],
    input  hub_switch_pkg::dest_t leaf_in_tdest   [`HUB_NUM_LEAF],
    input  hub_switch_pkg::id_t   leaf_in_tid     [`HUB_NUM_LEAF],
    input  logic                  leaf_in_tvalid  [`HUB_NUM_LEAF],
    output logic                  leaf_in_tready  [`HUB_NUM_LEAF],

    // leaf outputs
    output hub_switch_pkg::data_t leaf_out_tdata  [`HUB_NUM_LEAF],
    output hub_switch_pkg::dest_t leaf_out_tdest  [`HUB_NUM_LEAF],
    output hub_switch_pkg::id_t   leaf_out_tid    [`HUB_NUM_LEAF],
    output logic                  leaf_out_tvalid [`HUB_NUM_LEAF],
    input  logic                  leaf_out_tready [`HUB_NUM_LEAF]
);

    // demux to leaf slices
    hub_switch_pkg::data_t dmx_tdata  [`HUB_NUM_LEAF];
    hub_switch_pkg::dest_t dmx_tdest  [`HUB_NUM_LEAF];
    hub_switch_pkg::id_t   dmx_tid    [`HUB_NUM_LEAF];
    logic                  dmx_tvalid [`HUB_NUM_LEAF];
    logic                  dmx_tready [`HUB_NUM_LEAF];

    // arbiter to hub slice
    hub_switch_pkg::data_t arb_tdata;
    hub_switch_pkg::dest_t arb_tdest;
    hub_switch_pkg::id_t   arb_tid;
    logic                  arb_tvalid;
    logic                  arb_tready;

    axis_hub_demux i_demux (
        .clk         (clk),
        .rst         (rst),
        .hub_tdata   (hub_in_tdata),
        .hub_tdest   (hub_in_tdest),
        .hub_tid     (hub_in_tid),
        .hub_tvalid  (hub_in_tvalid),
        .hub_tready  (hub_in_tready),
        .leaf_tdata  (dmx_tdata),
        .leaf_tdest  (dmx_tdest),
        .leaf_tid    (dmx_tid),
        .leaf_tvalid (dmx_tvalid),
        .leaf_tready (dmx_tready)
    );

    // one output register per leaf
    for (genvar i = 0; i < `HUB_NUM_LEAF; i++) begin : g_leaf_out
        axis_skid_slice i_slice (
            .clk        (clk),
            .rst        (rst),
            .in_tdata   (dmx_tdata[i]),
            .in_tdest   (dmx_tdest[i]),
            .in_tid     (dmx_tid[i]),
            .in_tvalid  (dmx_tvalid[i]),
            .in_tready  (dmx_tready[i]),
            .out_tdata  (leaf_out_tdata[i]),
            .out_tdest  (leaf_out_tdest[i]),
            .out_tid    (leaf_out_tid[i]),
            .out_tvalid (leaf_out_tvalid[i]),
            .out_tready (leaf_out_tready[i])
        );
    end

    axis_leaf_arbiter i_arbiter (
        .clk         (clk),
        .rst         (rst),
        .leaf_tdata  (leaf_in_tdata),
        .leaf_tdest  (leaf_in_tdest),
        .leaf_tid    (leaf_in_tid),
        .leaf_tvalid (leaf_in_tvalid),
        .leaf_tready (leaf_in_tready),
        .hub_tdata   (arb_tdata),
        .hub_tdest   (arb_tdest),
        .hub_tid     (arb_tid),
        .hub_tvalid  (arb_tvalid),
        .hub_tready  (arb_tready)
    );

    axis_skid_slice i_hub_slice (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (arb_tdata),
        .in_tdest   (arb_tdest),
        .in_tid     (arb_tid),
        .in_tvalid  (arb_tvalid),
        .in_tready  (arb_tready),
        .out_tdata  (hub_out_tdata),
        .out_tdest  (hub_out_tdest),
        .out_tid    (hub_out_tid),
        .out_tvalid (hub_out_tvalid),
        .out_tready (hub_out_tready)
    );

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;  // released just after the edge, like the stimulus
    end

endmodule

/* verif/tb_axis_hub_switch.sv */
`timescale 1ns/1ps
`include "hub_switch_consts.svh"

module tb_axis_hub_switch;

    localparam int NUM_LEAF          = `HUB_NUM_LEAF;
    localparam int BURST_LEN         = 4;    // beats per leaf in a burst test
    localparam int TEST_LIMIT        = 200;  // cycles a test may take to drain
    localparam int SETTLE_CYCLES     = 8;    // quiet window to catch stray beats
    localparam int WATCHDOG_PER_TEST = 300;

    typedef struct packed {
        hub_switch_pkg::data_t data;
        hub_switch_pkg::dest_t dest;
        hub_switch_pkg::id_t   id;
    } beat_t;

    logic clk;
    logic rst;

    // DUT inputs, idle until the driver takes over
    hub_switch_pkg::data_t hub_in_tdata = '0;
    hub_switch_pkg::dest_t hub_in_tdest = '0;
    hub_switch_pkg::id_t   hub_in_tid = '0;
    logic                  hub_in_tvalid = 1'b0;
    logic                  hub_out_tready = 1'b1;
    hub_switch_pkg::data_t leaf_in_tdata [NUM_LEAF] = '{default: '0};
    hub_switch_pkg::dest_t leaf_in_tdest [NUM_LEAF] = '{default: '0};
    hub_switch_pkg::id_t   leaf_in_tid [NUM_LEAF] = '{default: '0};
    logic                  leaf_in_tvalid [NUM_LEAF] = '{default: 1'b0};
    logic                  leaf_out_tready [NUM_LEAF] = '{default: 1'b1};

    // DUT outputs
    logic                  hub_in_tready;
    hub_switch_pkg::data_t hub_out_tdata;
    hub_switch_pkg::dest_t hub_out_tdest;
    hub_switch_pkg::id_t   hub_out_tid;
    logic                  hub_out_tvalid;
    logic                  leaf_in_tready [NUM_LEAF];
    hub_switch_pkg::data_t leaf_out_tdata [NUM_LEAF];
    hub_switch_pkg::dest_t leaf_out_tdest [NUM_LEAF];
    hub_switch_pkg::id_t   leaf_out_tid [NUM_LEAF];
    logic                  leaf_out_tvalid [NUM_LEAF];

    // source queues, head is the beat on the wire
    beat_t hub_src_q [$];
    beat_t leaf_src_q [NUM_LEAF][$];
    // scoreboard, one queue per output port
    beat_t exp_hub_q [$];
    beat_t exp_leaf_q [NUM_LEAF][$];
    logic  hub_fire = 1'b0;
    logic  leaf_fire [NUM_LEAF] = '{default: 1'b0};
    integer seed = 32'hc8e797c8;

    // vector columns
    string                 name_q [$];
    string                 kind_q [$];
    int                    mask_q [$];
    int                    dest_q [$];
    int                    id_q [$];
    hub_switch_pkg::data_t data_q [$];

    string cur_name = "reset_state";
    int    test_errors = 0;
    int    pass_count = 0;
    int    fail_count = 0;
    bit    load_done = 1'b0;

    tb_clock_gen i_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    axis_hub_switch i_dut (
        .clk             (clk),
        .rst             (rst),
        .hub_in_tdata    (hub_in_tdata),
        .hub_in_tdest    (hub_in_tdest),
        .hub_in_tid      (hub_in_tid),
        .hub_in_tvalid   (hub_in_tvalid),
        .hub_in_tready   (hub_in_tready),
        .hub_out_tdata   (hub_out_tdata),
        .hub_out_tdest   (hub_out_tdest),
        .hub_out_tid     (hub_out_tid),
        .hub_out_tvalid  (hub_out_tvalid),
        .hub_out_tready  (hub_out_tready),
        .leaf_in_tdata   (leaf_in_tdata),
        .leaf_in_tdest   (leaf_in_tdest),
        .leaf_in_tid     (leaf_in_tid),
        .leaf_in_tvalid  (leaf_in_tvalid),
        .leaf_in_tready  (leaf_in_tready),
        .leaf_out_tdata  (leaf_out_tdata),
        .leaf_out_tdest  (leaf_out_tdest),
        .leaf_out_tid    (leaf_out_tid),
        .leaf_out_tvalid (leaf_out_tvalid),
        .leaf_out_tready (leaf_out_tready)
    );

    function automatic beat_t make_beat(input hub_switch_pkg::data_t data,
                                        input hub_switch_pkg::dest_t dest,
                                        input hub_switch_pkg::id_t id);
        beat_t b;
        b.data = data;
        b.dest = dest;
        b.id   = id;
        return b;
    endfunction

    task automatic check_data(input string what, input hub_switch_pkg::data_t exp,
                              input hub_switch_pkg::data_t act);
        if (act !== exp) begin
            $display("** Error: %0s %0s expected %h actual %h", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_dest(input string what, input hub_switch_pkg::dest_t exp,
                              input hub_switch_pkg::dest_t act);
        if (act !== exp) begin
            $display("** Error: %0s %0s expected %0d actual %0d", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_id(input string what, input hub_switch_pkg::id_t exp,
                            input hub_switch_pkg::id_t act);
        if (act !== exp) begin
            $display("** Error: %0s %0s expected %0d actual %0d", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_beat(input string port, input beat_t exp,
                              input hub_switch_pkg::data_t data,
                              input hub_switch_pkg::dest_t dest,
                              input hub_switch_pkg::id_t id);
        check_data({port, " tdata"}, exp.data, data);
        check_dest({port, " tdest"}, exp.dest, dest);
        check_id({port, " tid"}, exp.id, id);
    endtask

    // tdest 1..NUM_LEAF lands on leaf tdest-1, anything else is dropped
    function automatic void expect_down(input beat_t b);
        int d;
        d = int'(b.dest);
        if (d >= 1 && d <= NUM_LEAF) begin
            exp_leaf_q[d - 1].push_back(b);
        end
    endfunction

    task automatic take_leaf_beat(input int i);
        beat_t exp;
        if (exp_leaf_q[i].size() == 0) begin
            $display("%0s: unexpected beat on leaf %0d output, tdata %h",
                     cur_name, i, leaf_out_tdata[i]);
            test_errors++;
        end else begin
            exp = exp_leaf_q[i].pop_front();
            check_beat($sformatf("leaf%0d", i), exp, leaf_out_tdata[i],
                       leaf_out_tdest[i], leaf_out_tid[i]);
        end
    endtask

    task automatic take_hub_beat();
        beat_t exp;
        if (exp_hub_q.size() == 0) begin
            $display("%0s: unexpected beat on hub output, tdata %h", cur_name, hub_out_tdata);
            test_errors++;
        end else begin
            exp = exp_hub_q.pop_front();
            check_beat("hub", exp, hub_out_tdata, hub_out_tdest, hub_out_tid);
        end
    endtask

    // everything is stable mid-cycle, so handshakes are sampled at the falling edge
    always @(negedge clk) begin
        hub_fire = hub_in_tvalid && hub_in_tready;
        for (int i = 0; i < NUM_LEAF; i++) begin
            leaf_fire[i] = leaf_in_tvalid[i] && leaf_in_tready[i];
        end
        if (!rst) begin
            for (int i = 0; i < NUM_LEAF; i++) begin
                if (leaf_out_tvalid[i] && leaf_out_tready[i]) begin
                    take_leaf_beat(i);
                end
            end
            if (hub_out_tvalid && hub_out_tready) begin
                take_hub_beat();
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (hub_fire && hub_src_q.size() != 0) begin
            void'(hub_src_q.pop_front());
        end
        hub_in_tvalid = (hub_src_q.size() != 0);
        hub_in_tdata  = hub_in_tvalid ? hub_src_q[0].data : '0;
        hub_in_tdest  = hub_in_tvalid ? hub_src_q[0].dest : '0;
        hub_in_tid    = hub_in_tvalid ? hub_src_q[0].id : '0;
        for (int i = 0; i < NUM_LEAF; i++) begin
            if (leaf_fire[i] && leaf_src_q[i].size() != 0) begin
                void'(leaf_src_q[i].pop_front());
            end
            leaf_in_tvalid[i] = (leaf_src_q[i].size() != 0);
            leaf_in_tdata[i]  = leaf_in_tvalid[i] ? leaf_src_q[i][0].data : '0;
            leaf_in_tdest[i]  = leaf_in_tvalid[i] ? leaf_src_q[i][0].dest : '0;
            leaf_in_tid[i]    = leaf_in_tvalid[i] ? leaf_src_q[i][0].id : '0;
            leaf_out_tready[i] = ($random(seed) & 3) != 0;
        end
        hub_out_tready = ($random(seed) & 3) != 0;  // ready about three cycles in four
    end

    task automatic load_vectors(output bit ok);
        int                    fd;
        int                    n;
        string                 line;
        string                 name;
        string                 kind;
        int                    mask;
        int                    dest;
        int                    id;
        hub_switch_pkg::data_t data;
        ok = 1'b0;
        fd = $fopen("verif/hub_switch_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/hub_switch_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %d %d %h", name, kind, mask, dest, id, data);
                    if (n == 6) begin
                        name_q.push_back(name);
                        kind_q.push_back(kind);
                        mask_q.push_back(mask);
                        dest_q.push_back(dest);
                        id_q.push_back(id);
                        data_q.push_back(data);
                    end
                end
            end
            $fclose(fd);
            ok = (name_q.size() != 0);
            if (!ok) begin
                $display("vector file holds no usable test line");
            end
        end
    endtask

    task automatic check_outputs_idle(input string phase);
        if (hub_out_tvalid) begin
            $display("%0s: hub output tvalid high %0s", cur_name, phase);
            test_errors++;
        end
        for (int i = 0; i < NUM_LEAF; i++) begin
            if (leaf_out_tvalid[i]) begin
                $display("%0s: leaf %0d output tvalid high %0s", cur_name, i, phase);
                test_errors++;
            end
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("%0s: ok", cur_name);
        end else begin
            fail_count++;
            $display("%0s: %0d errors", cur_name, test_errors);
        end
    endtask

    task automatic check_reset_state();
        cur_name    = "reset_state";
        test_errors = 0;
        @(negedge clk);
        while (rst) begin
            check_outputs_idle("during reset");
            @(negedge clk);
        end
        @(negedge clk);  // one cycle after the release
        check_outputs_idle("after reset");
        if (!hub_in_tready) begin
            $display("%0s: hub input tready still low after reset", cur_name);
            test_errors++;
        end
        finish_test();
    endtask

    function automatic bit queues_busy();
        bit busy;
        busy = (hub_src_q.size() != 0) || (exp_hub_q.size() != 0);
        for (int i = 0; i < NUM_LEAF; i++) begin
            busy = busy || (leaf_src_q[i].size() != 0) || (exp_leaf_q[i].size() != 0);
        end
        return busy;
    endfunction

    task automatic report_leftovers();
        if (hub_src_q.size() != 0) begin
            $display("%0s: hub input never took %0d beats", cur_name, hub_src_q.size());
            test_errors++;
        end
        if (exp_hub_q.size() != 0) begin
            $display("%0s: hub output is missing %0d beats", cur_name, exp_hub_q.size());
            test_errors++;
        end
        for (int i = 0; i < NUM_LEAF; i++) begin
            if (leaf_src_q[i].size() != 0) begin
                $display("%0s: leaf %0d input never took %0d beats",
                         cur_name, i, leaf_src_q[i].size());
                test_errors++;
            end
            if (exp_leaf_q[i].size() != 0) begin
                $display("%0s: leaf %0d output is missing %0d beats",
                         cur_name, i, exp_leaf_q[i].size());
                test_errors++;
            end
            leaf_src_q[i].delete();
            exp_leaf_q[i].delete();
        end
        hub_src_q.delete();
        exp_hub_q.delete();
    endtask

    task automatic run_test(input int t);
        beat_t                 b;
        hub_switch_pkg::dest_t dest;
        hub_switch_pkg::id_t   id;
        int                    mask;
        int                    beats;
        int                    cycles;
        cur_name    = name_q[t];
        test_errors = 0;
        mask        = mask_q[t];
        dest        = hub_switch_pkg::dest_t'(dest_q[t]);
        id          = hub_switch_pkg::id_t'(id_q[t]);
        beats       = (kind_q[t] == "uburst") ? BURST_LEN : 1;
        @(posedge clk);  // queue up ahead of the drive slot
        if (kind_q[t] == "down") begin
            b = make_beat(data_q[t], dest, id);
            hub_src_q.push_back(b);
            expect_down(b);
        end else if (kind_q[t] == "dburst") begin
            for (int k = 0; k < BURST_LEN; k++) begin
                for (int i = 0; i < NUM_LEAF; i++) begin
                    if (mask[i]) begin
                        b = make_beat(data_q[t] + hub_switch_pkg::data_t'(k * 256 + i),
                                      hub_switch_pkg::dest_t'(i + 1), id);
                        hub_src_q.push_back(b);
                        expect_down(b);
                    end
                end
            end
        end else if (kind_q[t] == "up" || kind_q[t] == "uburst") begin
            // fixed priority, so the lowest leaf drains completely first
            for (int i = 0; i < NUM_LEAF; i++) begin
                for (int k = 0; k < beats; k++) begin
                    if (mask[i]) begin
                        b = make_beat(data_q[t] + hub_switch_pkg::data_t'(k * 256 + i), dest, id);
                        leaf_src_q[i].push_back(b);
                        if (dest == hub_switch_pkg::dest_t'(`HUB_DEST_HUB)) begin
                            exp_hub_q.push_back(b);
                        end
                    end
                end
            end
        end else begin
            $display("%0s: unknown test kind %0s", cur_name, kind_q[t]);
            test_errors++;
        end
        cycles = 0;
        while (queues_busy() && cycles < TEST_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (queues_busy()) begin
            $display("%0s: not drained after %0d cycles", cur_name, TEST_LIMIT);
            report_leftovers();
        end
        repeat (SETTLE_CYCLES) @(posedge clk);
        finish_test();
    endtask

    initial begin
        bit loaded;
        load_vectors(loaded);
        load_done = 1'b1;
        check_reset_state();
        if (loaded) begin
            for (int t = 0; t < name_q.size(); t++) begin
                run_test(t);
            end
        end else begin
            fail_count++;
        end
        $display("%0d tests run, %0d ok, %0d failing",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // budget grows with the number of tests
    initial begin
        wait (load_done);
        repeat ((name_q.size() + 1) * WATCHDOG_PER_TEST) @(posedge clk);
        $display("watchdog: run still busy after %0d clock cycles, stopped",
                 (name_q.size() + 1) * WATCHDOG_PER_TEST);
        $display("test failed");
        $finish;
    end

endmodule

/* hub_switch.f */
+incdir+include
src/hub_switch_pkg.sv
src/axis_skid_slice.sv
src/axis_hub_demux.sv
src/axis_leaf_arbiter.sv
src/axis_hub_switch.sv
verif/tb_clock_gen.sv
verif/tb_axis_hub_switch.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the hub switch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_axis_hub_switch \
    -f hub_switch.f \
    -Mdir obj_dir

./obj_dir/Vtb_axis_hub_switch > sim.log
cat sim.log

# the testbench prints its pass line only when every check held
if grep -qx "test passed" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi

/* verif/hub_switch_vectors.txt */
# name kind mask(hex) tdest tid tdata(hex, 128 bits)
# down: one hub beat, up: one beat per leaf in mask with tdata + leaf index
# dburst: 4 hub beats per leaf in mask (tdest unused), uburst: 4 beats from each leaf in mask
down_leaf0     down   0 1  0 00112233445566778899aabbccddeeff
down_leaf1     down   0 2  1 0123456789abcdef0123456789abcdef
down_leaf2     down   0 3  2 fedcba9876543210fedcba9876543210
down_leaf3     down   0 4  3 deadbeefcafef00d0badc0de12345678
down_zero      down   0 3  0 00000000000000000000000000000000
down_ones      down   0 2  3 ffffffffffffffffffffffffffffffff
down_disc_hub  down   0 0  0 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
down_after_hub down   0 1  1 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
down_disc_5    down   0 5  2 11111111222222223333333344444444
down_after_5   down   0 4  2 80000000000000000000000000000001
down_disc_9    down   0 9  1 13572468135724689bdf8ace9bdf8ace
down_disc_15   down   0 15 3 c0ffee00c0ffee00c0ffee00c0ffee00
down_after_15  down   0 2  0 0f0f0f0ff0f0f0f00f0f0f0ff0f0f0f0
up_leaf0       up     1 0  0 10203040506070809Aa0b0c0d0e0f000
up_leaf1       up     2 0  1 76543210fedcba9876543210fedcba00
up_leaf2       up     4 0  2 2468ace02468ace02468ace02468ac00
up_leaf3       up     8 0  3 00112233445566778899aabbccddee00
up_pair_03     up     9 0  1 0123456789abcdef0123456789abcd00
up_pair_12     up     6 0  2 fedcba9876543210fedcba9876543200
up_three       up     e 0  3 deadbeefcafef00d0badc0de12345600
up_all         up     f 0  0 ffffffffffffffffffffffffffffff00
up_all_id      up     f 0  3 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a500
up_disc_one    up     4 2  0 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a00
up_disc_all    up     f 1  1 11111111222222223333333344444400
up_disc_high   up     f 15 2 c0ffee00c0ffee00c0ffee00c0ffee00
up_after_disc  up     f 0  1 13572468135724689bdf8ace9bdf8a00
dburst_leaf0   dburst 1 0  0 0f0f0f0ff0f0f0f00f0f0f0ff0f00000
dburst_pair    dburst 5 0  1 76543210fedcba9876543210fedc0000
dburst_odd     dburst a 0  2 2468ace02468ace02468ace024680000
dburst_all     dburst f 0  3 00112233445566778899aabbccdd0000
dburst_all2    dburst f 0  0 80000000000000000000000000000000
uburst_leaf3   uburst 8 0  1 deadbeefcafef00d0badc0de12340000
uburst_pair    uburst 6 0  2 0123456789abcdef0123456789ab0000
uburst_all     uburst f 0  3 fedcba9876543210fedcba9876540000
uburst_disc    uburst f 3  0 a5a5a5a5a5a5a5a5a5a5a5a5a5a50000
uburst_all2    uburst f 0  1 10203040506070809000a0b0c0d00000
